/* hw/u1e_settings.svh */
////////////////////////////////////////////////////////////
// byte addressed 16 bit bus, 32 bit settings words
// tick rate assumes a 64 MHz wb_clk
////////////////////////////////////////////////////////////
`ifndef U1E_SETTINGS_SVH
`define U1E_SETTINGS_SVH

// bus widths
`define U1E_DW 16
`define U1E_AW 11
`define U1E_SW 2

// slot numbers, adr[10:7]
`define U1E_SLOT_MISC     0
`define U1E_SLOT_SETTINGS 5

// misc register offsets, adr[6:0]
`define U1E_REG_LEDS        0
`define U1E_REG_SWITCHES    2
`define U1E_REG_CGEN_CTRL   4
`define U1E_REG_CGEN_ST     6
`define U1E_REG_TEST        8
`define U1E_REG_RX_FRAMELEN 10
`define U1E_REG_TX_FRAMELEN 12
`define U1E_REG_XFER_RATE   14
`define U1E_REG_COMPAT      16

`define U1E_CGEN_CTRL_RESET 3         // sync_b and ref_sel high
`define U1E_COMPAT_WORD     16'h0002  // whoami 0, compat 2
`define U1E_READ_DEFAULT    16'hBEEF

// settings bus addresses
`define U1E_SR_CLEAR_FIFO   6
`define U1E_SR_TIME64       28        // secs, ticks, ctrl
`define U1E_TICKS_PER_SEC   64000000

`endif

/* hw/u1e_pkg.sv */
////////////////////////////////////////////////////////////
// bus and status bundles shared by the core and its slaves
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

package u1e_pkg;

   // master to slave
   typedef struct packed {
      logic [`U1E_AW-1:0] adr;
      logic [`U1E_DW-1:0] dat;
      logic [`U1E_SW-1:0] sel;
      logic               we;
      logic               cyc;
      logic               stb;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic [`U1E_DW-1:0] dat;
      logic               ack;
   } wb_rsp_t;

   // 32 bit settings write, one cycle strobe
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic       tx_enable;
      logic       rx_enable;
      logic [7:0] rate;
   } xfer_ctrl_t;

   // clock generator pins
   typedef struct packed {
      logic status;
      logic ld;
      logic refmon;
   } cgen_status_t;

   typedef struct packed {
      logic [31:0] secs;
      logic [31:0] ticks;
   } vita_time_t;

endpackage

/* hw/u1e_wb_decoder.sv */
////////////////////////////////////////////////////////////
// only adr[10:7] is decoded; unmapped slots ack with zero
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

module u1e_wb_decoder
  (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  u1e_pkg::wb_req_t m_req_i,
   output u1e_pkg::wb_rsp_t m_rsp_o,
   output u1e_pkg::wb_req_t misc_req_o,
   input  u1e_pkg::wb_rsp_t misc_rsp_i,
   output u1e_pkg::wb_req_t set_req_o,
   input  u1e_pkg::wb_rsp_t set_rsp_i
  );

   logic [3:0] slot;
   logic       bus_en_q;   // bus accepted from the first cycle after reset
   logic       hit_misc;
   logic       hit_set;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         bus_en_q <= 1'b0;
      else
         bus_en_q <= 1'b1;
   end

   assign slot     = m_req_i.adr[10:7];
   assign hit_misc = bus_en_q & (slot == 4'(`U1E_SLOT_MISC));
   assign hit_set  = bus_en_q & (slot == 4'(`U1E_SLOT_SETTINGS));

   // request fans out, cyc only to the matching slave
   always_comb
   begin
      misc_req_o     = m_req_i;
      misc_req_o.cyc = m_req_i.cyc & hit_misc;
      set_req_o      = m_req_i;
      set_req_o.cyc  = m_req_i.cyc & hit_set;
   end

   always_comb
   begin
      if (hit_misc)
         m_rsp_o = misc_rsp_i;
      else if (hit_set)
         m_rsp_o = set_rsp_i;
      else
         m_rsp_o = '{dat: '0, ack: bus_en_q & m_req_i.cyc & m_req_i.stb}; // empty slot
   end

endmodule

/* hw/u1e_misc_regs.sv */
////////////////////////////////////////////////////////////
// slot 0 registers, full 16 bit writes, sel is not used
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

module u1e_misc_regs
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  u1e_pkg::wb_req_t      req_i,
   output u1e_pkg::wb_rsp_t      rsp_o,
   input  u1e_pkg::cgen_status_t cgen_st_i,
   input  logic [15:0]           rx_frame_len_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   output logic [3:0]            debug_led_o,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   output u1e_pkg::xfer_ctrl_t   xfer_o,
   output logic [15:0]           tx_frame_len_o,
   output logic [15:0]           test_o
  );

   logic [6:0]         offset;
   logic               wr_en;
   logic [`U1E_DW-1:0] reg_leds;
   logic [`U1E_DW-1:0] reg_cgen_ctrl;
   logic [`U1E_DW-1:0] reg_test;
   logic [`U1E_DW-1:0] reg_tx_len;
   logic [`U1E_DW-1:0] reg_xfer;
   logic [`U1E_DW-1:0] rd_data;

   assign offset = req_i.adr[6:0];
   assign wr_en  = req_i.cyc & req_i.stb & req_i.we;

   ////////////////////////////////////////////////////////////
   // writable registers
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= 16'(`U1E_CGEN_CTRL_RESET);
         reg_test      <= '0;
         reg_tx_len    <= '0;
         reg_xfer      <= '0;
      end
      else if (wr_en)
      begin
         case (offset)
            7'(`U1E_REG_LEDS):        reg_leds      <= req_i.dat;
            7'(`U1E_REG_CGEN_CTRL):   reg_cgen_ctrl <= req_i.dat;
            7'(`U1E_REG_TEST):        reg_test      <= req_i.dat;
            7'(`U1E_REG_TX_FRAMELEN): reg_tx_len    <= req_i.dat;
            7'(`U1E_REG_XFER_RATE):   reg_xfer      <= req_i.dat;
            default:                  ;  // read only or unused offset
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // readback
   always_comb
   begin
      case (offset)
         7'(`U1E_REG_LEDS):        rd_data = reg_leds;
         7'(`U1E_REG_SWITCHES):    rd_data = '0;
         7'(`U1E_REG_CGEN_CTRL):   rd_data = reg_cgen_ctrl;
         7'(`U1E_REG_CGEN_ST):     rd_data = {13'd0, cgen_st_i.status, cgen_st_i.ld,
                                              cgen_st_i.refmon};
         7'(`U1E_REG_TEST):        rd_data = reg_test;
         7'(`U1E_REG_RX_FRAMELEN): rd_data = rx_frame_len_i;
         7'(`U1E_REG_TX_FRAMELEN): rd_data = reg_tx_len;
         7'(`U1E_REG_XFER_RATE):   rd_data = reg_xfer;
         7'(`U1E_REG_COMPAT):      rd_data = `U1E_COMPAT_WORD;
         default:                  rd_data = `U1E_READ_DEFAULT;
      endcase
   end

   assign rsp_o = '{dat: rd_data, ack: req_i.cyc & req_i.stb};

   // leds are active low on the board
   assign debug_led_o    = ~{run_rx_i, run_tx_i, reg_leds[1:0]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign xfer_o         = '{tx_enable: reg_xfer[15], rx_enable: reg_xfer[14],
                             rate: reg_xfer[7:0]};
   assign tx_frame_len_o = reg_tx_len;
   assign test_o         = reg_test;

endmodule

/* hw/u1e_settings_bus.sv */
////////////////////////////////////////////////////////////
// write low half first, the high half write fires the strobe
// settings space is write only, reads give zero
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

module u1e_settings_bus
  (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  u1e_pkg::wb_req_t  req_i,
   output u1e_pkg::wb_rsp_t  rsp_o,
   output u1e_pkg::set_bus_t set_o,
   output logic              clear_tx_o,
   output logic              clear_rx_o
  );

   logic               wr_en;
   logic               wr_lo;
   logic               wr_hi;
   logic [`U1E_DW-1:0] lo_q;        // held until the high half arrives
   logic               set_stb_q;
   logic [7:0]         set_addr_q;
   logic [31:0]        set_data_q;
   logic               hit_clear;

   assign wr_en = req_i.cyc & req_i.stb & req_i.we;
   assign wr_lo = wr_en & ~req_i.adr[1];
   assign wr_hi = wr_en & req_i.adr[1];

   ////////////////////////////////////////////////////////////
   // half word assembly
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_q <= 1'b0;
      else
         set_stb_q <= wr_hi;  // one cycle, after the high half
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         lo_q <= req_i.dat;
      if (wr_hi)
      begin
         set_addr_q <= {3'b000, req_i.adr[6:2]};
         set_data_q <= {req_i.dat, lo_q};
      end
   end

   assign set_o = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};

   assign rsp_o = '{dat: '0, ack: req_i.cyc & req_i.stb};

   ////////////////////////////////////////////////////////////
   // fifo clear, bit 1 tx and bit 0 rx
   assign hit_clear  = set_stb_q & (set_addr_q == 8'(`U1E_SR_CLEAR_FIFO));
   assign clear_tx_o = hit_clear & set_data_q[1];
   assign clear_rx_o = hit_clear & set_data_q[0];

endmodule

/* hw/u1e_vita_time.sv */
////////////////////////////////////////////////////////////
// pps_i is async, seen 3 cycles late; ticks_per_sec >= 2
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

module u1e_vita_time
  #(
   parameter int unsigned ticks_per_sec = `U1E_TICKS_PER_SEC
  )
  (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  u1e_pkg::set_bus_t   set_i,
   input  logic                pps_i,
   output u1e_pkg::vita_time_t vita_time_o,
   output logic                pps_int_o
  );

   import u1e_pkg::*;

   vita_time_t time_q;
   vita_time_t pend_q;     // time to load, now or at pps
   logic       armed_q;
   logic [2:0] pps_sq;     // 2 sync flops + previous value
   logic       pps_rise;
   logic       pps_int_q;
   logic       ctl_wr;
   logic       load_now;
   logic       load_pps;
   logic       wrap;

   ////////////////////////////////////////////////////////////
   // pps synchronizer and edge detect
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sq    <= '0;
         pps_int_q <= 1'b0;
      end
      else
      begin
         pps_sq    <= {pps_sq[1:0], pps_i};
         pps_int_q <= pps_rise;
      end
   end

   assign pps_rise = pps_sq[1] & ~pps_sq[2];

   ////////////////////////////////////////////////////////////
   // settings registers
   assign ctl_wr   = set_i.stb && (set_i.addr == 8'(`U1E_SR_TIME64 + 2));
   assign load_now = ctl_wr & set_i.data[0];
   assign load_pps = pps_int_q & armed_q;

   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && (set_i.addr == 8'(`U1E_SR_TIME64)))
         pend_q.secs <= set_i.data;
      if (set_i.stb && (set_i.addr == 8'(`U1E_SR_TIME64 + 1)))
         pend_q.ticks <= set_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         armed_q <= 1'b0;
      else if (ctl_wr)
         armed_q <= ~set_i.data[0];  // bit 0 clear waits for pps
      else if (pps_int_q)
         armed_q <= 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // seconds and ticks counter
   assign wrap = (time_q.ticks == 32'(ticks_per_sec - 1));

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         time_q <= '0;
      else if (load_now || load_pps)
         time_q <= pend_q;
      else if (wrap)
      begin
         time_q.ticks <= '0;
         time_q.secs  <= time_q.secs + 32'd1;
      end
      else
         time_q.ticks <= time_q.ticks + 32'd1;
   end

   assign vita_time_o = time_q;
   assign pps_int_o   = pps_int_q;

endmodule

/* hw/u1e_core.sv */
////////////////////////////////////////////////////////////
// single clock control plane, bus master is external
// only slots 0 and 5 are populated
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

module u1e_core
  #(
   parameter int unsigned ticks_per_sec = `U1E_TICKS_PER_SEC
  )
  (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  u1e_pkg::wb_req_t      bus_req_i,
   output u1e_pkg::wb_rsp_t      bus_rsp_o,
   input  u1e_pkg::cgen_status_t cgen_st_i,
   input  logic [15:0]           rx_frame_len_i,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  pps_i,
   output logic [3:0]            debug_led_o,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   output u1e_pkg::xfer_ctrl_t   xfer_o,
   output logic [15:0]           tx_frame_len_o,
   output logic [15:0]           test_o,
   output logic                  clear_tx_o,
   output logic                  clear_rx_o,
   output u1e_pkg::vita_time_t   vita_time_o,
   output logic                  pps_int_o
  );

   import u1e_pkg::*;

   wb_req_t  misc_req;
   wb_rsp_t  misc_rsp;
   wb_req_t  set_req;
   wb_rsp_t  set_rsp;
   set_bus_t set_bus;

   ////////////////////////////////////////////////////////////
   // bus fabric
   u1e_wb_decoder u1e_wb_decoder_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .m_req_i(bus_req_i), .m_rsp_o(bus_rsp_o),
      .misc_req_o(misc_req), .misc_rsp_i(misc_rsp),
      .set_req_o(set_req), .set_rsp_i(set_rsp));

   // slot 0
   u1e_misc_regs u1e_misc_regs_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_i(cgen_st_i), .rx_frame_len_i(rx_frame_len_i),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .xfer_o(xfer_o), .tx_frame_len_o(tx_frame_len_o), .test_o(test_o));

   // slot 5
   u1e_settings_bus u1e_settings_bus_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .req_i(set_req), .rsp_o(set_rsp),
      .set_o(set_bus),
      .clear_tx_o(clear_tx_o), .clear_rx_o(clear_rx_o));

   ////////////////////////////////////////////////////////////
   // timekeeping, fed from the settings bus
   u1e_vita_time #(.ticks_per_sec(ticks_per_sec)) u1e_vita_time_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time_o), .pps_int_o(pps_int_o));

endmodule

/* verif/u1e_core_asserts.sv */
////////////////////////////////////////////////////////////
// bound to u1e_core, all checks idle while wb_rst is high
////////////////////////////////////////////////////////////
module u1e_core_asserts
  (
   input logic             wb_clk,
   input logic             wb_rst,
   input u1e_pkg::wb_req_t bus_req_i,
   input u1e_pkg::wb_rsp_t bus_rsp_o,
   input logic             clear_tx_o,
   input logic             clear_rx_o,
   input logic             pps_int_o
  );

   int fail_count = 0;

   // ack is combinational on cyc and stb
   ack_needs_strobe: assert property (@(posedge wb_clk) disable iff (wb_rst)
      bus_rsp_o.ack |-> (bus_req_i.cyc && bus_req_i.stb))
   else
   begin
      fail_count++;
      $error("ack seen without cyc and stb");
   end

   clear_tx_one_shot: assert property (@(posedge wb_clk) disable iff (wb_rst)
      clear_tx_o |=> !clear_tx_o)
   else
   begin
      fail_count++;
      $error("clear_tx_o high for more than one cycle");
   end

   clear_rx_one_shot: assert property (@(posedge wb_clk) disable iff (wb_rst)
      clear_rx_o |=> !clear_rx_o)
   else
   begin
      fail_count++;
      $error("clear_rx_o high for more than one cycle");
   end

   pps_int_one_shot: assert property (@(posedge wb_clk) disable iff (wb_rst)
      pps_int_o |=> !pps_int_o)
   else
   begin
      fail_count++;
      $error("pps_int_o high for two cycles");
   end

endmodule

bind u1e_core u1e_core_asserts u1e_core_asserts_inst
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_req_i(bus_req_i), .bus_rsp_o(bus_rsp_o),
   .clear_tx_o(clear_tx_o), .clear_rx_o(clear_rx_o), .pps_int_o(pps_int_o));

/* verif/u1e_core_tb.sv */
////////////////////////////////////////////////////////////
// directed tests, core built with a 20 tick second
////////////////////////////////////////////////////////////
`include "u1e_settings.svh"

module u1e_core_tb;

   import u1e_pkg::*;

   localparam int TPS         = 20;
   localparam int BUS_TIMEOUT = 16;   // cycles to wait for ack
   localparam int WAIT_LIMIT  = 64;

   logic         wb_clk = 1'b0;
   logic         wb_rst;
   wb_req_t      bus_req;
   wb_rsp_t      bus_rsp;
   cgen_status_t cgen_st;
   logic [15:0]  rx_frame_len;
   logic         run_rx;
   logic         run_tx;
   logic         pps;
   logic [3:0]   debug_led;
   logic         cgen_sync_b;
   logic         cgen_ref_sel;
   xfer_ctrl_t   xfer;
   logic [15:0]  tx_frame_len;
   logic [15:0]  test_reg;
   logic         clear_tx;
   logic         clear_rx;
   vita_time_t   vita_time;
   logic         pps_int;

   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          clear_tx_cnt = 0;
   int          clear_rx_cnt = 0;
   int          pps_int_cnt = 0;
   logic [31:0] rng = 32'hd694c443;

   u1e_core #(.ticks_per_sec(TPS)) u1e_core_inst
     (.wb_clk(wb_clk), .wb_rst(wb_rst), .bus_req_i(bus_req), .bus_rsp_o(bus_rsp),
      .cgen_st_i(cgen_st), .rx_frame_len_i(rx_frame_len),
      .run_rx_i(run_rx), .run_tx_i(run_tx), .pps_i(pps),
      .debug_led_o(debug_led), .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel),
      .xfer_o(xfer), .tx_frame_len_o(tx_frame_len), .test_o(test_reg),
      .clear_tx_o(clear_tx), .clear_rx_o(clear_rx),
      .vita_time_o(vita_time), .pps_int_o(pps_int));

   always #4 wb_clk = ~wb_clk;

   // one shot outputs, counted at every edge
   always @(posedge wb_clk)
   begin
      if (!wb_rst)
      begin
         clear_tx_cnt <= clear_tx_cnt + (clear_tx ? 1 : 0);
         clear_rx_cnt <= clear_rx_cnt + (clear_rx ? 1 : 0);
         pps_int_cnt  <= pps_int_cnt + (pps_int ? 1 : 0);
      end
   end

   ////////////////////////////////////////////////////////////
   // helpers
   function automatic logic [15:0] next_random();
      rng = rng ^ (rng << 13);   // xorshift32
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng[15:0];
   endfunction

   function automatic logic [10:0] misc_adr(input int off);
      return {4'(`U1E_SLOT_MISC), 7'(off)};
   endfunction

   function automatic logic [10:0] set_adr(input int sa, input logic hi);
      return {4'(`U1E_SLOT_SETTINGS), 5'(sa), hi, 1'b0};
   endfunction

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic finish_test(input string name, input int start);
      tests++;
      $display("%-22s done, %0d errors", name, errors - start);
   endtask

   // one transfer, request held until ack
   task automatic bus_cycle(input logic we, input logic [10:0] addr,
                            input logic [15:0] wdat, output logic [15:0] rdat);
      int   waited;
      logic acked;
      waited = 0;
      acked  = 1'b0;
      rdat   = 'x;
      @(negedge wb_clk);
      bus_req = '{adr: addr, dat: wdat, sel: 2'b11, we: we, cyc: 1'b1, stb: 1'b1};
      while (!acked && waited < BUS_TIMEOUT)
      begin
         @(posedge wb_clk);
         acked = bus_rsp.ack;
         rdat  = bus_rsp.dat;
         waited++;
      end
      @(negedge wb_clk);
      bus_req = '0;   // stb low for at least a cycle
      if (!acked)
      begin
         errors++;
         $display("bus access at address 0x%0h was never acknowledged", addr);
      end
   endtask

   task automatic bus_write(input logic [10:0] addr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_cycle(1'b1, addr, dat, unused);
   endtask

   task automatic bus_read(input logic [10:0] addr, output logic [15:0] dat);
      bus_cycle(1'b0, addr, 16'h0000, dat);
   endtask

   task automatic settings_write(input int sa, input logic [31:0] data);
      bus_write(set_adr(sa, 1'b0), data[15:0]);
      bus_write(set_adr(sa, 1'b1), data[31:16]);
   endtask

   task automatic write_readback(input int off, input logic [15:0] v, input string name);
      logic [15:0] rd;
      bus_write(misc_adr(off), v);
      bus_read(misc_adr(off), rd);
      check_eq(name, rd, v);
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   task automatic verify_reset();
      int          start;
      logic [15:0] rd;
      start = errors;
      check_eq("vita_time_o", vita_time, 64'd0);   // no edge seen since reset release
      check_eq("xfer_o", xfer, 10'd0);
      check_eq("tx_frame_len_o", tx_frame_len, 16'd0);
      check_eq("cgen_sync_b_o", cgen_sync_b, 1'b1);
      check_eq("cgen_ref_sel_o", cgen_ref_sel, 1'b1);
      check_eq("debug_led_o", debug_led, 4'(~{run_rx, run_tx, 2'b00}));
      check_eq("clear_tx_o clear_rx_o pps_int_o", {clear_tx, clear_rx, pps_int}, 3'b000);
      bus_read(misc_adr(`U1E_REG_LEDS), rd);
      check_eq("leds read", rd, 16'h0000);
      bus_read(misc_adr(`U1E_REG_CGEN_CTRL), rd);
      check_eq("cgen_ctrl read", rd, 16'h0003);
      finish_test("reset values", start);
   endtask

   task automatic exercise_misc_regs();
      int          start;
      logic [15:0] v;
      start = errors;
      v = next_random();
      write_readback(`U1E_REG_TEST, v, "test read");
      check_eq("test_o", test_reg, v);
      v = next_random();
      write_readback(`U1E_REG_TX_FRAMELEN, v, "tx_frame_len read");
      check_eq("tx_frame_len_o", tx_frame_len, v);
      v = next_random();
      write_readback(`U1E_REG_XFER_RATE, v, "xfer_rate read");
      check_eq("xfer_o", xfer, {v[15], v[14], v[7:0]});  // tx_en, rx_en, rate
      v = next_random();
      write_readback(`U1E_REG_LEDS, v, "leds read");
      check_eq("debug_led_o", debug_led, 4'(~{run_rx, run_tx, v[1:0]}));
      v = next_random();
      write_readback(`U1E_REG_CGEN_CTRL, v, "cgen_ctrl read");
      check_eq("cgen_sync_b_o cgen_ref_sel_o", {cgen_sync_b, cgen_ref_sel}, v[1:0]);
      finish_test("misc registers", start);
   endtask

   task automatic probe_readonly_space();
      int          start;
      logic [15:0] st;
      logic [15:0] len;
      logic [15:0] rd;
      start = errors;
      st  = next_random();
      len = next_random();
      @(negedge wb_clk);
      cgen_st      = st[2:0];
      rx_frame_len = len;
      bus_read(misc_adr(`U1E_REG_CGEN_ST), rd);
      check_eq("cgen_st read", rd, {13'd0, st[2:0]});
      bus_read(misc_adr(`U1E_REG_RX_FRAMELEN), rd);
      check_eq("rx_frame_len read", rd, len);
      bus_read(misc_adr(`U1E_REG_COMPAT), rd);
      check_eq("compat read", rd, 16'h0002);
      bus_read(misc_adr(`U1E_REG_SWITCHES), rd);
      check_eq("switches read", rd, 16'h0000);
      bus_read(misc_adr(7'h50), rd);   // no register here
      check_eq("unknown offset read", rd, 16'hBEEF);
      bus_read({4'd3, 7'd0}, rd);
      check_eq("slot 3 read", rd, 16'h0000);
      finish_test("read only space", start);
   endtask

   task automatic pulse_fifo_clear();
      int start;
      int tx0;
      int rx0;
      start = errors;
      tx0   = clear_tx_cnt;
      rx0   = clear_rx_cnt;
      settings_write(`U1E_SR_CLEAR_FIFO, 32'd2);
      repeat (3) @(negedge wb_clk);
      check_eq("clear_tx_o pulses", clear_tx_cnt - tx0, 1);
      check_eq("clear_rx_o pulses", clear_rx_cnt - rx0, 0);
      settings_write(`U1E_SR_CLEAR_FIFO, 32'd1);
      repeat (3) @(negedge wb_clk);
      check_eq("clear_tx_o pulses", clear_tx_cnt - tx0, 1);
      check_eq("clear_rx_o pulses", clear_rx_cnt - rx0, 1);
      // neighbouring address, both flags set
      settings_write(`U1E_SR_CLEAR_FIFO + 1, 32'd3);
      repeat (3) @(negedge wb_clk);
      check_eq("clear_tx_o pulses", clear_tx_cnt - tx0, 1);
      check_eq("clear_rx_o pulses", clear_rx_cnt - rx0, 1);
      finish_test("fifo clear", start);
   endtask

   task automatic load_time_now();
      int start;
      int waited;
      start = errors;
      settings_write(`U1E_SR_TIME64, 32'd5);
      settings_write(`U1E_SR_TIME64 + 1, 32'd18);
      settings_write(`U1E_SR_TIME64 + 2, 32'd1);   // bit 0 set, load at once
      @(negedge wb_clk);
      check_eq("vita_time_o after load", vita_time, {32'd5, 32'd18});
      waited = 0;
      while (vita_time.secs != 32'd6 && waited < WAIT_LIMIT)
      begin
         @(negedge wb_clk);
         waited++;
      end
      check_eq("vita_time_o after wrap", vita_time, {32'd6, 32'd0});
      check_eq("cycles to second wrap", waited, TPS - 18);
      finish_test("immediate time load", start);
   endtask

   task automatic load_time_at_pps();
      int   start;
      int   waited;
      int   p0;
      logic seen;
      start = errors;
      p0    = pps_int_cnt;
      settings_write(`U1E_SR_TIME64, 32'd100);
      settings_write(`U1E_SR_TIME64 + 1, 32'd0);
      settings_write(`U1E_SR_TIME64 + 2, 32'd0);   // arm for next pps
      @(negedge wb_clk);
      pps    = 1'b1;
      seen   = 1'b0;
      waited = 0;
      while (!seen && waited < WAIT_LIMIT)
      begin
         @(posedge wb_clk);
         seen = pps_int;
         waited++;
      end
      @(negedge wb_clk);
      pps = 1'b0;
      if (!seen)
      begin
         errors++;
         $display("pps_int_o never pulsed after the pps_i edge");
      end
      check_eq("vita_time_o at pps", vita_time, {32'd100, 32'd0});
      repeat (4) @(negedge wb_clk);
      check_eq("pps_int_o pulses", pps_int_cnt - p0, 1);
      finish_test("pps time load", start);
   endtask

   ////////////////////////////////////////////////////////////
   // sequence
   initial
   begin
      int assert_fails;
      wb_rst       = 1'b1;
      bus_req      = '0;
      cgen_st      = '0;
      rx_frame_len = '0;
      run_rx       = 1'b1;
      run_tx       = 1'b0;
      pps          = 1'b0;
      repeat (10) @(negedge wb_clk);
      wb_rst = 1'b0;
      verify_reset();
      exercise_misc_regs();
      probe_readonly_space();
      pulse_fifo_clear();
      load_time_now();
      load_time_at_pps();
      assert_fails = u1e_core_inst.u1e_core_asserts_inst.fail_count;
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* compile.f */
+incdir+hw
hw/u1e_pkg.sv
hw/u1e_wb_decoder.sv
hw/u1e_misc_regs.sv
hw/u1e_settings_bus.sv
hw/u1e_vita_time.sv
hw/u1e_core.sv
verif/u1e_core_asserts.sv
verif/u1e_core_tb.sv

/* Bender.yml */
package:
  name: u1e_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/u1e_pkg.sv
      - hw/u1e_wb_decoder.sv
      - hw/u1e_misc_regs.sv
      - hw/u1e_settings_bus.sv
      - hw/u1e_vita_time.sv
      - hw/u1e_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/u1e_core_asserts.sv
      - verif/u1e_core_tb.sv
